//--- hdl/vector_unit_pkg.sv
package vector_unit_pkg;

    // ------------------------------------------------------------------------
    // Widths with a meaning
    // ------------------------------------------------------------------------

    // One architectural register: operand, accumulator or result
    typedef logic [31:0] word_t;

    // All products of one multiply, packed as four 16-bit or two 32-bit lanes
    typedef logic [63:0] prod_t;

    // A single lane product for 8-bit and for 16-bit elements
    typedef logic [15:0] prod8_t;
    typedef logic [31:0] prod16_t;

    // Sum of two 32-bit terms plus the accumulator, one guard bit for Q31
    typedef logic [32:0] wide_sum_t;

    // Saturation limits of the fixed-point formats
    localparam word_t   Q31_MAX = 32'h7FFF_FFFF;
    localparam word_t   Q31_MIN = 32'h8000_0000;
    localparam logic [15:0] Q15_MAX = 16'h7FFF;
    localparam logic [15:0] Q15_MIN = 16'h8000;
    localparam logic [7:0]  Q7_MAX  = 8'h7F;
    localparam logic [7:0]  Q7_MIN  = 8'h80;

    // ------------------------------------------------------------------------
    // Control encodings
    // ------------------------------------------------------------------------

    // How a 32-bit operand is split into elements
    typedef enum logic {
        BIT8  = 1'b0,
        BIT16 = 1'b1
    } esize_t;

    // Micro-operations of the multiply-accumulate back end
    typedef enum logic [1:0] {
        VACC   = 2'b00,
        VSAT   = 2'b01,
        FAS    = 2'b10,
        FAS_RD = 2'b11
    } vacc_uops_t;

    // ------------------------------------------------------------------------
    // Stage payloads
    // ------------------------------------------------------------------------

    // Everything that leaves the multiplier stage, 99 bits
    typedef struct packed {
        prod_t      prod;
        word_t      acc;
        vacc_uops_t op;
        esize_t     esize;
    } vmul_out_t;

    // Result of one of the two parallel paths
    typedef struct packed {
        word_t result;
        logic  ovf;
    } path_res_t;

endpackage : vector_unit_pkg

//--- hdl/vector_multiplier.sv
`timescale 1ns/1ps

module vector_multiplier (
    input  logic                          clk_i,
    input  logic                          clk_en_i,
    input  vector_unit_pkg::word_t        operand_a_i,
    input  vector_unit_pkg::word_t        operand_b_i,
    input  vector_unit_pkg::word_t        accumulator_i,
    input  vector_unit_pkg::vacc_uops_t   operation_i,
    input  vector_unit_pkg::esize_t       element_size_i,
    output vector_unit_pkg::vmul_out_t    mul_o
);

    import vector_unit_pkg::*;

    // Signed lane products for both element sizes
    logic signed [15:0] lane8 [4];
    logic signed [31:0] lane16 [2];

    // Packed products of the selected size
    prod_t products;

    // ------------------------------------------------------------------------
    // Lane multipliers
    // ------------------------------------------------------------------------

    always_comb begin
        // Both operands are signed, so the product is sign extended to the lane
        for (int i = 0; i < 4; i++) begin
            lane8[i] = $signed(operand_a_i[8*i +: 8]) * $signed(operand_b_i[8*i +: 8]);
        end

        // The 16-bit lanes reuse the same operand bits split in halves
        for (int i = 0; i < 2; i++) begin
            lane16[i] = $signed(operand_a_i[16*i +: 16]) * $signed(operand_b_i[16*i +: 16]);
        end
    end

    // Pack the lanes of the selected size into one 64-bit word
    always_comb begin
        products = '0;
        if (element_size_i == BIT16) begin
            for (int i = 0; i < 2; i++) begin
                products[32*i +: 32] = prod16_t'(lane16[i]);
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                products[16*i +: 16] = prod8_t'(lane8[i]);
            end
        end
    end

    // ------------------------------------------------------------------------
    // Stage register
    // ------------------------------------------------------------------------

    // Products travel with the accumulator and the control fields
    always_ff @(posedge clk_i) begin
        if (clk_en_i) begin
            mul_o.prod  <= products;
            mul_o.acc   <= accumulator_i;
            mul_o.op    <= operation_i;
            mul_o.esize <= element_size_i;
        end
    end

endmodule : vector_multiplier

//--- hdl/vector_reduce.sv
`timescale 1ns/1ps

module vector_reduce (
    input  logic                          clk_i,
    input  logic                          clk_en_i,
    input  vector_unit_pkg::vmul_out_t    mul_i,
    output vector_unit_pkg::path_res_t    red_o
);

    import vector_unit_pkg::*;

    // Byte products seen as four 16-bit lanes
    prod8_t      p8 [4];
    // Halfword products seen as two 32-bit lanes
    prod16_t     p16 [2];

    logic [16:0] pair_sum [2];
    logic [17:0] dot8;
    word_t       vacc_res;

    wide_sum_t   acc_term;
    wide_sum_t   dot16;
    word_t       q31_res;
    logic        q31_ovf;

    path_res_t   red_d;

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            p8[i] = mul_i.prod[16*i +: 16];
        end
        for (int i = 0; i < 2; i++) begin
            p16[i] = mul_i.prod[32*i +: 32];
        end
    end

    // ------------------------------------------------------------------------
    // 8-bit dot product, two-level adder tree
    // ------------------------------------------------------------------------

    // First level adds neighbouring lanes with one bit of growth
    assign pair_sum[0] = {p8[0][15], p8[0]} + {p8[1][15], p8[1]};
    assign pair_sum[1] = {p8[2][15], p8[2]} + {p8[3][15], p8[3]};

    assign dot8 = {pair_sum[0][16], pair_sum[0]} + {pair_sum[1][16], pair_sum[1]};

    // VACC wraps modulo 2^32 and never reports overflow
    assign vacc_res = mul_i.acc + {{14{dot8[17]}}, dot8};

    // ------------------------------------------------------------------------
    // 16-bit dot product with Q31 saturation
    // ------------------------------------------------------------------------

    // Only FAS_RD adds the destination register
    assign acc_term = (mul_i.op == FAS_RD) ? {mul_i.acc[31], mul_i.acc} : '0;

    assign dot16 = {p16[0][31], p16[0]} + {p16[1][31], p16[1]} + acc_term;

    always_comb begin
        // Guard bit and sign bit disagree when the sum left the Q31 range
        q31_ovf = dot16[32] ^ dot16[31];
        if (q31_ovf) begin
            q31_res = dot16[32] ? Q31_MIN : Q31_MAX;
        end else begin
            q31_res = dot16[31:0];
        end
    end

    // VSAT results of this path are dropped later by the result mux
    always_comb begin
        if (mul_i.op == VACC) begin
            red_d = '{result: vacc_res, ovf: 1'b0};
        end else begin
            red_d = '{result: q31_res, ovf: q31_ovf};
        end
    end

    always_ff @(posedge clk_i) begin
        if (clk_en_i) begin
            red_o <= red_d;
        end
    end

endmodule : vector_reduce

//--- hdl/vector_saturate.sv
`timescale 1ns/1ps

module vector_saturate (
    input  logic                          clk_i,
    input  logic                          clk_en_i,
    input  vector_unit_pkg::vmul_out_t    mul_i,
    output vector_unit_pkg::path_res_t    sat_o
);

    import vector_unit_pkg::*;

    // Products after the arithmetic shift back to Q7 or Q15
    logic signed [15:0] sh8 [4];
    logic signed [31:0] sh16 [2];

    // One flag per lane that had to be clamped
    logic [3:0] clamp8;
    logic [1:0] clamp16;

    word_t      res8;
    word_t      res16;
    path_res_t  sat_d;

    // ------------------------------------------------------------------------
    // Q7 lanes
    // ------------------------------------------------------------------------

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            sh8[i] = $signed(mul_i.prod[16*i +: 16]) >>> 7;

            // The value fits a byte only if every bit above bit 7 copies the sign
            clamp8[i] = (sh8[i][15:7] != {9{sh8[i][7]}});

            if (clamp8[i]) begin
                res8[8*i +: 8] = sh8[i][15] ? Q7_MIN : Q7_MAX;
            end else begin
                res8[8*i +: 8] = sh8[i][7:0];
            end
        end
    end

    // ------------------------------------------------------------------------
    // Q15 lanes
    // ------------------------------------------------------------------------

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            sh16[i] = $signed(mul_i.prod[32*i +: 32]) >>> 15;

            // Only -32768 times -32768 can leave the Q15 range
            clamp16[i] = (sh16[i][31:15] != {17{sh16[i][15]}});

            if (clamp16[i]) begin
                res16[16*i +: 16] = sh16[i][31] ? Q15_MIN : Q15_MAX;
            end else begin
                res16[16*i +: 16] = sh16[i][15:0];
            end
        end
    end

    // The flag is the OR over every lane of the chosen size
    always_comb begin
        if (mul_i.esize == BIT16) begin
            sat_d = '{result: res16, ovf: |clamp16};
        end else begin
            sat_d = '{result: res8, ovf: |clamp8};
        end
    end

    always_ff @(posedge clk_i) begin
        if (clk_en_i) begin
            sat_o <= sat_d;
        end
    end

endmodule : vector_saturate

//--- hdl/vector_result_mux.sv
`timescale 1ns/1ps

module vector_result_mux (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          clk_en_i,
    input  logic                          valid_i,
    input  logic                          clear_sat_i,
    input  vector_unit_pkg::vacc_uops_t   operation_i,
    input  vector_unit_pkg::path_res_t    red_i,
    input  vector_unit_pkg::path_res_t    sat_i,
    output vector_unit_pkg::word_t        result_o,
    output logic                          overflow_o,
    output logic                          sat_sticky_o
);

    import vector_unit_pkg::*;

    // ------------------------------------------------------------------------
    // Result select
    // ------------------------------------------------------------------------

    always_comb begin
        case (operation_i)
            // Per-lane fixed-point result
            VSAT: begin
                result_o   = sat_i.result;
                overflow_o = sat_i.ovf;
            end
            // Wrapping accumulate has no overflow by definition
            VACC: begin
                result_o   = red_i.result;
                overflow_o = 1'b0;
            end
            // FAS and FAS_RD report the Q31 clamp
            default: begin
                result_o   = red_i.result;
                overflow_o = red_i.ovf;
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // Sticky saturation status
    // ------------------------------------------------------------------------

    // Clearing wins over a saturating output on the same edge
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            sat_sticky_o <= 1'b0;
        end else if (clk_en_i) begin
            if (clear_sat_i) begin
                sat_sticky_o <= 1'b0;
            end else if (valid_i && overflow_o) begin
                sat_sticky_o <= 1'b1;
            end
        end
    end

endmodule : vector_result_mux

//--- hdl/vector_unit.sv
`timescale 1ns/1ps

module vector_unit (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  vector_unit_pkg::word_t        operand_a_i,
    input  vector_unit_pkg::word_t        operand_b_i,
    input  vector_unit_pkg::word_t        accumulator_i,
    input  vector_unit_pkg::vacc_uops_t   operation_i,
    input  vector_unit_pkg::esize_t       element_size_i,
    input  logic                          data_valid_i,
    input  logic                          clk_en_i,
    input  logic                          clear_sat_i,
    output vector_unit_pkg::word_t        result_o,
    output logic                          overflow_o,
    output logic                          sat_sticky_o,
    output logic                          data_valid_o
);

    import vector_unit_pkg::*;

    vmul_out_t  mul;
    path_res_t  red;
    path_res_t  sat;

    // Operation copy that travels beside the two parallel paths
    vacc_uops_t op_q;

    // Valid strobe, one bit per pipeline stage
    logic [1:0] valid_q;

    vector_multiplier i_vector_multiplier (
        .clk_i          (clk_i),
        .clk_en_i       (clk_en_i),
        .operand_a_i    (operand_a_i),
        .operand_b_i    (operand_b_i),
        .accumulator_i  (accumulator_i),
        .operation_i    (operation_i),
        .element_size_i (element_size_i),
        .mul_o          (mul)
    );

    // Both paths consume the same multiplier stage in parallel
    vector_reduce i_vector_reduce (
        .clk_i    (clk_i),
        .clk_en_i (clk_en_i),
        .mul_i    (mul),
        .red_o    (red)
    );

    vector_saturate i_vector_saturate (
        .clk_i    (clk_i),
        .clk_en_i (clk_en_i),
        .mul_i    (mul),
        .sat_o    (sat)
    );

    always_ff @(posedge clk_i) begin
        if (clk_en_i) begin
            op_q <= mul.op;
        end
    end

    // The strobe only moves on enabled edges, like the datapath
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (clk_en_i) begin
            valid_q <= {valid_q[0], data_valid_i};
        end
    end

    assign data_valid_o = valid_q[1];

    vector_result_mux i_vector_result_mux (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .clk_en_i     (clk_en_i),
        .valid_i      (valid_q[1]),
        .clear_sat_i  (clear_sat_i),
        .operation_i  (op_q),
        .red_i        (red),
        .sat_i        (sat),
        .result_o     (result_o),
        .overflow_o   (overflow_o),
        .sat_sticky_o (sat_sticky_o)
    );

endmodule : vector_unit

//--- tests/vector_unit_assert.sv
`timescale 1ns/1ps

module vector_unit_assert (
    input logic clk_i,
    input logic rst_n_i,
    input logic clk_en_i,
    input logic data_valid_i,
    input logic data_valid_o,
    input logic sat_sticky_o
);

    // Input strobe as taken by the last two enabled edges
    logic [1:0] seen_valid;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            seen_valid <= '0;
        end else if (clk_en_i) begin
            seen_valid <= {seen_valid[0], data_valid_i};
        end
    end

    // ------------------------------------------------------------------------
    // Valid timing
    // ------------------------------------------------------------------------

    // A strobe leaves exactly two enabled edges after it was taken
    valid_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        data_valid_o == seen_valid[1])
        else $error("data_valid_o does not follow data_valid_i by two enabled edges");

    // A disabled edge freezes the strobe and the sticky status
    hold_on_disable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !clk_en_i |=> $stable(data_valid_o) && $stable(sat_sticky_o))
        else $error("valid or sticky status moved on an edge with clk_en_i low");

    // Both status outputs are cleared by every reset edge
    reset_state: assert property (@(posedge clk_i)
        !rst_n_i |=> !data_valid_o && !sat_sticky_o)
        else $error("data_valid_o or sat_sticky_o high while reset is held");

endmodule : vector_unit_assert

bind vector_unit vector_unit_assert i_vector_unit_assert (.*);

//--- tests/tb_vector_unit.sv
`timescale 1ns/1ps

module tb_vector_unit;

    import vector_unit_pkg::*;

    localparam int NUM_SAMPLES = 200;
    localparam int CLK_HALF    = 50;
    // A sample takes about 1.5 cycles on average and 4 leaves room for long enable gaps
    localparam int WATCHDOG_CYCLES = NUM_SAMPLES * 4 + 100;

    // Q31 range of the dot-product paths
    localparam longint Q31_HI = 64'sd2147483647;
    localparam longint Q31_LO = -64'sd2147483648;

    // ------------------------------------------------------------------------
    // Directed corners forced in on every fourth sample
    // ------------------------------------------------------------------------

    // Lanes of -128 and -32768 squared, a single clamped lane, Q31 at both ends and a VACC wrap
    localparam word_t CORNER_A [8] = '{32'h8080_8080, 32'h807F_0180, 32'h8000_8000,
        32'h8000_1234, 32'h8000_8000, 32'h8000_8000, 32'h8000_8000, 32'h7F7F_7F7F};
    localparam word_t CORNER_B [8] = '{32'h8080_8080, 32'h8080_0101, 32'h8000_8000,
        32'h8000_0002, 32'h8000_8000, 32'h7FFF_7FFF, 32'h8000_8000, 32'h7F7F_7F7F};
    localparam word_t CORNER_ACC [8] = '{32'h0, 32'h0, 32'h0, 32'h0,
        32'h7FFF_FFFF, 32'h8000_0000, 32'h0000_0001, 32'hFFFF_FFF0};
    localparam vacc_uops_t CORNER_OP [8] = '{VSAT, VSAT, VSAT, VSAT, FAS, FAS_RD, FAS_RD, VACC};
    localparam esize_t CORNER_ES [8] = '{BIT8, BIT8, BIT16, BIT16, BIT16, BIT16, BIT16, BIT8};

    logic       clk_i = 1'b0;
    logic       rst_n_i;
    word_t      operand_a_i;
    word_t      operand_b_i;
    word_t      accumulator_i;
    vacc_uops_t operation_i;
    esize_t     element_size_i;
    logic       data_valid_i;
    logic       clk_en_i;
    logic       clear_sat_i;
    word_t      result_o;
    logic       overflow_o;
    logic       sat_sticky_o;
    logic       data_valid_o;

    logic [31:0] seed = 32'd95679;
    logic        running = 1'b0;
    int          issued = 0;
    int          checked = 0;
    int          val_errs = 0;
    int          proto_errs = 0;

    // Expected {overflow, result} per accepted sample with the oldest first
    logic [32:0] exp_q [$];
    string       name_q [$];

    // Outputs seen at the previous edge and the expected sticky status
    word_t last_result;
    logic  last_ovf;
    logic  last_valid;
    logic  prev_en = 1'b1;
    logic  sticky_exp = 1'b0;

    vector_unit i_vector_unit (.*);

    always #CLK_HALF clk_i = ~clk_i;

    function logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Clamps a shifted lane to a signed field of the given width and sets bit 16 on a clamp
    function automatic logic [16:0] clamp_lane(input longint v, input int bits);
        longint hi;
        longint lo;
        hi = (longint'(1) <<< (bits - 1)) - 1;
        lo = -hi - 1;
        if (v > hi) begin
            return {1'b1, 16'(hi)};
        end else if (v < lo) begin
            return {1'b1, 16'(lo)};
        end
        return {1'b0, 16'(v)};
    endfunction

    // Expected {overflow, result} worked out from the element rules of each operation
    function automatic logic [32:0] model(input word_t a, input word_t b, input word_t acc,
                                          input vacc_uops_t op, input esize_t es);
        longint      sum;
        logic [16:0] lane;
        word_t       res;
        logic        ovf;
        sum = 0;
        res = '0;
        ovf = 1'b0;
        if (op == VACC) begin
            for (int i = 0; i < 4; i++) begin
                sum += longint'($signed(a[8*i +: 8])) * longint'($signed(b[8*i +: 8]));
            end
            res = acc + word_t'(sum);
        end else if (op == VSAT && es == BIT8) begin
            for (int i = 0; i < 4; i++) begin
                lane = clamp_lane((longint'($signed(a[8*i +: 8]))
                                   * longint'($signed(b[8*i +: 8]))) >>> 7, 8);
                res[8*i +: 8] = lane[7:0];
                ovf |= lane[16];
            end
        end else if (op == VSAT) begin
            for (int i = 0; i < 2; i++) begin
                lane = clamp_lane((longint'($signed(a[16*i +: 16]))
                                   * longint'($signed(b[16*i +: 16]))) >>> 15, 16);
                res[16*i +: 16] = lane[15:0];
                ovf |= lane[16];
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                sum += longint'($signed(a[16*i +: 16])) * longint'($signed(b[16*i +: 16]));
            end
            // FAS leaves the accumulator out of the sum
            if (op == FAS_RD) begin
                sum += longint'($signed(acc));
            end
            ovf = (sum > Q31_HI) || (sum < Q31_LO);
            res = (sum > Q31_HI) ? 32'h7FFF_FFFF : (sum < Q31_LO) ? 32'h8000_0000 : word_t'(sum);
        end
        return {ovf, res};
    endfunction

    // Drives the next operand set with VACC always on bytes and FAS on halfwords
    task automatic next_sample(input int idx);
        word_t      a;
        word_t      b;
        word_t      acc;
        word_t      sel;
        vacc_uops_t op;
        esize_t     es;
        a = lcg_next();
        b = lcg_next();
        acc = lcg_next();
        sel = lcg_next();
        op = vacc_uops_t'(sel[31:30]);
        es = (op == VSAT) ? esize_t'(sel[20]) : (op == VACC) ? BIT8 : BIT16;
        if (idx % 4 == 0) begin
            a = CORNER_A[(idx / 4) % 8];
            b = CORNER_B[(idx / 4) % 8];
            acc = CORNER_ACC[(idx / 4) % 8];
            op = CORNER_OP[(idx / 4) % 8];
            es = CORNER_ES[(idx / 4) % 8];
        end
        operand_a_i <= a;
        operand_b_i <= b;
        accumulator_i <= acc;
        operation_i <= op;
        element_size_i <= es;
    endtask

    // ------------------------------------------------------------------------
    // Checking and stimulus both run on the rising edge with pre-edge values
    // ------------------------------------------------------------------------

    always @(posedge clk_i) begin
        logic [31:0] r;
        logic [32:0] expected;
        string       name;
        logic        out_ovf;
        if (running) begin
            out_ovf = 1'b0;
            // Nothing may move across an edge that had the enable low
            if (!prev_en) begin
                assert (result_o == last_result && overflow_o == last_ovf
                        && data_valid_o == last_valid) else begin
                    $display("outputs changed across an edge with clk_en_i low");
                    proto_errs++;
                end
            end
            assert (sat_sticky_o == sticky_exp) else begin
                $display("ERR sticky: expected %0b actual %0b", sticky_exp, sat_sticky_o);
                val_errs++;
            end
            if (clk_en_i) begin
                // An output is consumed by the enabled edge that ends it
                if (data_valid_o && exp_q.size() == 0) begin
                    $display("valid output with no accepted sample outstanding");
                    proto_errs++;
                end else if (data_valid_o) begin
                    expected = exp_q.pop_front();
                    name = name_q.pop_front();
                    out_ovf = expected[32];
                    assert (result_o == expected[31:0]) else begin
                        $display("ERR %s result: expected %h actual %h",
                                 name, expected[31:0], result_o);
                        val_errs++;
                    end
                    assert (overflow_o == expected[32]) else begin
                        $display("ERR %s overflow: expected %0b actual %0b",
                                 name, expected[32], overflow_o);
                        val_errs++;
                    end
                    checked++;
                end
                // Clear has priority over a saturating output
                if (clear_sat_i) begin
                    sticky_exp = 1'b0;
                end else if (out_ovf) begin
                    sticky_exp = 1'b1;
                end
                if (data_valid_i) begin
                    exp_q.push_back(model(operand_a_i, operand_b_i, accumulator_i,
                                          operation_i, element_size_i));
                    name_q.push_back($sformatf("%s_%s", operation_i.name(),
                                               element_size_i.name()));
                end
            end
            last_result = result_o;
            last_ovf = overflow_o;
            last_valid = data_valid_o;
            prev_en = clk_en_i;
            r = lcg_next();
            // A pending sample is held until an enabled edge takes it
            if (!data_valid_i || clk_en_i) begin
                if (issued < NUM_SAMPLES && r[27:26] != 2'b00) begin
                    next_sample(issued);
                    issued++;
                    data_valid_i <= 1'b1;
                end else begin
                    data_valid_i <= 1'b0;
                end
            end
            clk_en_i <= (r[31:29] != 3'b000);
            clear_sat_i <= (r[25:21] == 5'b00000);
        end
    end

    initial begin
        rst_n_i = 1'b0;
        operand_a_i = '0;
        operand_b_i = '0;
        accumulator_i = '0;
        operation_i = VACC;
        element_size_i = BIT8;
        data_valid_i = 1'b0;
        clk_en_i = 1'b1;
        clear_sat_i = 1'b0;
        repeat (5) @(posedge clk_i);
        rst_n_i <= 1'b1;
        running <= 1'b1;
        while (checked < NUM_SAMPLES) begin
            @(negedge clk_i);
        end
        repeat (4) @(negedge clk_i);
        $display("checked %0d of %0d samples, %0d value errors, %0d other errors",
                 checked, NUM_SAMPLES, val_errs, proto_errs);
        if (val_errs == 0 && proto_errs == 0 && exp_q.size() == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Ends a run whose outputs stopped coming
    initial begin
        #(WATCHDOG_CYCLES * 2 * CLK_HALF);
        $display("watchdog expired with %0d of %0d samples checked", checked, NUM_SAMPLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule : tb_vector_unit

//--- build.f
hdl/vector_unit_pkg.sv
hdl/vector_multiplier.sv
hdl/vector_reduce.sv
hdl/vector_saturate.sv
hdl/vector_result_mux.sv
hdl/vector_unit.sv
tests/vector_unit_assert.sv
tests/tb_vector_unit.sv

//--- Makefile
# Verilator build and run of the vector unit testbench

VERILATOR ?= verilator
TOP       ?= tb_vector_unit
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
